/* hdl/controlPkg.sv */
`default_nettype none

package controlPkg;

    localparam int opcodeWidth = 6;
    localparam int functWidth = 6;
    localparam int waitCountWidth = 2;

    ////////////////////////////////////////////////////////////////////
    // Instruction encodings
    ////////////////////////////////////////////////////////////////////
    localparam logic [opcodeWidth-1:0] opRType = 6'h00;
    localparam logic [opcodeWidth-1:0] opJ     = 6'h02;
    localparam logic [opcodeWidth-1:0] opJal   = 6'h03;
    localparam logic [opcodeWidth-1:0] opBeq   = 6'h04;
    localparam logic [opcodeWidth-1:0] opBne   = 6'h05;
    localparam logic [opcodeWidth-1:0] opBle   = 6'h06;
    localparam logic [opcodeWidth-1:0] opBgt   = 6'h07;
    localparam logic [opcodeWidth-1:0] opAddi  = 6'h08;
    localparam logic [opcodeWidth-1:0] opAddiu = 6'h09;
    localparam logic [opcodeWidth-1:0] opSlti  = 6'h0a;
    localparam logic [opcodeWidth-1:0] opLb    = 6'h20;
    localparam logic [opcodeWidth-1:0] opLh    = 6'h21;
    localparam logic [opcodeWidth-1:0] opLw    = 6'h23;
    localparam logic [opcodeWidth-1:0] opSb    = 6'h28;
    localparam logic [opcodeWidth-1:0] opSh    = 6'h29;
    localparam logic [opcodeWidth-1:0] opSw    = 6'h2b;

    localparam logic [functWidth-1:0] fnJr  = 6'h08;
    localparam logic [functWidth-1:0] fnAdd = 6'h20;
    localparam logic [functWidth-1:0] fnSub = 6'h22;
    localparam logic [functWidth-1:0] fnAnd = 6'h24;
    localparam logic [functWidth-1:0] fnOr  = 6'h25;
    localparam logic [functWidth-1:0] fnSlt = 6'h2a;

    typedef enum logic [4:0] {
        aluLoad     = 5'd0,  // Pass A through
        aluAddOvf   = 5'd1,
        aluSub      = 5'd2,
        aluAnd      = 5'd3,
        aluCmp      = 5'd7,  // Set on less than
        aluOr       = 5'd8,
        aluAddNoOvf = 5'd11,
        aluNe       = 5'd14,
        aluEq       = 5'd15,
        aluLe       = 5'd16,
        aluGt       = 5'd17
    } aluCtrl_t;

    typedef enum logic [3:0] {
        kindAluReg, kindJumpReg, kindAluImm, kindBranch, kindLoad,
        kindStore, kindJump, kindJal, kindInvalid
    } instrKind_t;

    typedef enum logic [1:0] {sizeWord, sizeHalf, sizeByte} memSize_t;

    typedef struct packed {
        instrKind_t kind;
        aluCtrl_t   aluOp;    // Execute or compare operation
        memSize_t   memSize;
    } decodedInstr_t;

    typedef enum logic [5:0] {
        stReset, stFetchWait, stFetchLoad, stDecode, stExecute, stWriteRd, stWriteRt,
        stBranchTarget, stBranchCompare, stBranchCommit, stAddrCalc, stMemRead,
        stMemLoad, stMemStore, stJump, stJal, stJumpReg, stJumpRegCommit,
        stInvalidOp, stOverflowTrap, stExceptionExit
    } ctrlState_t;

    ////////////////////////////////////////////////////////////////////
    // Datapath select codes
    ////////////////////////////////////////////////////////////////////
    localparam logic [2:0] pcSrcJump = 3'd0, pcSrcAluResult = 3'd1;
    localparam logic [2:0] pcSrcAluOut = 3'd2, pcSrcException = 3'd3;
    localparam logic [1:0] regDstRt = 2'd0, regDstRd = 2'd1, regDstRa = 2'd2, regDstSp = 2'd3;
    localparam logic [2:0] memToRegAlu = 3'd0, memToRegMem = 3'd1, memToRegSpInit = 3'd2;
    localparam logic [2:0] memToRegException = 3'd3, memToRegPc = 3'd4;
    localparam logic [2:0] srcAddrPc = 3'd0, srcAddrOverflow = 3'd1, srcAddrInvalid = 3'd3;
    localparam logic [2:0] sizeHandlerSb = 3'd0, sizeHandlerSw = 3'd1, sizeHandlerSh = 3'd2;
    localparam logic [2:0] sizeHandlerLb = 3'd3, sizeHandlerLw = 3'd4, sizeHandlerLh = 3'd5;
    localparam logic [2:0] aluBReg = 3'd0, aluBFour = 3'd1, aluBImm = 3'd2;
    localparam logic [2:0] aluBBranchOffset = 3'd3;

    localparam int fetchWaitCycles = 2;  // Memory latency on fetch
    localparam int resetInitCycles = 2;
    localparam int memReadCycles = 2;

    typedef struct packed {
        logic       pcWrite;
        logic       pcWriteCond;
        logic       iOrD;
        logic       memWrite;
        logic       irWrite;
        logic       dataSource;
        logic       regWrite;
        logic       aluSrcA;
        logic [2:0] srcAddr;
        logic [2:0] memToReg;
        logic [2:0] sizeHandler;
        logic [1:0] regDest;
        logic [2:0] aluSrcB;
        aluCtrl_t   aluControl;
        logic [2:0] pcSource;
    } controlWord_t;

endpackage

`default_nettype wire

/* hdl/instructionDecoder.sv */
`timescale 1ns/1ps
`default_nettype none

module instructionDecoder
    import controlPkg::*;
(
    input  logic [opcodeWidth-1:0] opcode,
    input  logic [functWidth-1:0]  funct,
    output decodedInstr_t          decoded
);

    always_comb
    begin
        decoded.kind = kindInvalid;  // Unlisted codes trap
        decoded.aluOp = aluLoad;
        decoded.memSize = sizeWord;

        case (opcode)
            opRType:
            begin
                decoded.kind = kindAluReg;
                case (funct)
                    fnSlt: decoded.aluOp = aluCmp;
                    fnSub: decoded.aluOp = aluSub;
                    fnAdd: decoded.aluOp = aluAddOvf;
                    fnAnd: decoded.aluOp = aluAnd;
                    fnOr:  decoded.aluOp = aluOr;
                    fnJr:  decoded.kind = kindJumpReg;
                    default: decoded.kind = kindInvalid;
                endcase
            end
            opAddi:
            begin
                decoded.kind = kindAluImm;
                decoded.aluOp = aluAddOvf;
            end
            opAddiu:
            begin
                decoded.kind = kindAluImm;
                decoded.aluOp = aluAddNoOvf;  // Never traps
            end
            opSlti:
            begin
                decoded.kind = kindAluImm;
                decoded.aluOp = aluCmp;
            end
            opBeq, opBne, opBle, opBgt:
            begin
                decoded.kind = kindBranch;
                case (opcode)
                    opBeq:   decoded.aluOp = aluEq;
                    opBne:   decoded.aluOp = aluNe;
                    opBle:   decoded.aluOp = aluLe;
                    default: decoded.aluOp = aluGt;
                endcase
            end
            opLw, opLh, opLb:
            begin
                decoded.kind = kindLoad;
                decoded.memSize = (opcode == opLw) ? sizeWord :
                                  (opcode == opLh) ? sizeHalf : sizeByte;
            end
            opSw, opSh, opSb:
            begin
                decoded.kind = kindStore;
                decoded.memSize = (opcode == opSw) ? sizeWord :
                                  (opcode == opSh) ? sizeHalf : sizeByte;
            end
            opJ:   decoded.kind = kindJump;
            opJal: decoded.kind = kindJal;
            default: decoded.kind = kindInvalid;
        endcase
    end

endmodule

`default_nettype wire

/* hdl/stateSequencer.sv */
`timescale 1ns/1ps
`default_nettype none

module stateSequencer
    import controlPkg::*;
(
    input  logic          clk,
    input  logic          reset,
    input  logic          overflow,
    input  decodedInstr_t decoded,
    output ctrlState_t    state
);

    ctrlState_t                nextState;
    logic [waitCountWidth-1:0] waitCount;
    logic [waitCountWidth-1:0] nextCount;
    logic [waitCountWidth-1:0] lastCount;
    logic                      waitDone;
    logic                      isStore;

    // Length of the current wait state, minus one
    always_comb
    begin
        case (state)
            stReset:     lastCount = waitCountWidth'(resetInitCycles - 1);
            stFetchWait: lastCount = waitCountWidth'(fetchWaitCycles - 1);
            default:     lastCount = waitCountWidth'(memReadCycles - 1);
        endcase
    end

    assign waitDone = (waitCount == lastCount);
    assign isStore = (decoded.kind == kindStore);

    ////////////////////////////////////////////////////////////////////
    // Next state
    ////////////////////////////////////////////////////////////////////
    always_comb
    begin
        nextState = state;
        nextCount = '0;

        case (state)
            stReset, stFetchWait:
            begin
                if (waitDone)
                    nextState = (state == stReset) ? stFetchWait : stFetchLoad;
                else
                    nextCount = waitCount + 1'b1;
            end
            stFetchLoad: nextState = stDecode;
            stDecode:
            begin
                case (decoded.kind)
                    kindAluReg, kindAluImm: nextState = stExecute;
                    kindJumpReg:            nextState = stJumpReg;
                    kindBranch:             nextState = stBranchTarget;
                    kindLoad, kindStore:    nextState = stAddrCalc;
                    kindJump:               nextState = stJump;
                    kindJal:                nextState = stJal;
                    default:                nextState = stInvalidOp;
                endcase
            end
            stExecute:
                nextState = (decoded.kind == kindAluImm) ? stWriteRt : stWriteRd;
            stBranchTarget:  nextState = stBranchCompare;
            stBranchCompare: nextState = stBranchCommit;
            stAddrCalc:
            begin
                // Partial stores merge with the old word first
                if (isStore && decoded.memSize == sizeWord)
                    nextState = stMemStore;
                else
                    nextState = stMemRead;
            end
            stMemRead:
            begin
                if (waitDone)
                    nextState = isStore ? stMemStore : stMemLoad;
                else
                    nextCount = waitCount + 1'b1;
            end
            stJumpReg: nextState = stJumpRegCommit;
            stInvalidOp, stOverflowTrap: nextState = stExceptionExit;
            default: nextState = stFetchWait;  // Last state of every body
        endcase

        if (overflow && state != stReset)
        begin
            nextState = stOverflowTrap;  // Beats every other transition
            nextCount = '0;
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state <= stReset;
            waitCount <= '0;
        end
        else
        begin
            state <= nextState;
            waitCount <= nextCount;
        end
    end

endmodule

`default_nettype wire

/* hdl/controlEncoder.sv */
`timescale 1ns/1ps
`default_nettype none

module controlEncoder
    import controlPkg::*;
(
    input  ctrlState_t    state,
    input  decodedInstr_t decoded,
    output controlWord_t  ctrl
);

    function automatic logic [2:0] loadSizeCode(memSize_t size);
        case (size)
            sizeHalf: return sizeHandlerLh;
            sizeByte: return sizeHandlerLb;
            default:  return sizeHandlerLw;
        endcase
    endfunction

    function automatic logic [2:0] storeSizeCode(memSize_t size);
        case (size)
            sizeHalf: return sizeHandlerSh;
            sizeByte: return sizeHandlerSb;
            default:  return sizeHandlerSw;
        endcase
    endfunction

    always_comb
    begin
        ctrl = '0;  // All strobes low
        ctrl.srcAddr = srcAddrPc;
        ctrl.memToReg = memToRegAlu;
        ctrl.regDest = regDstRt;
        ctrl.aluSrcB = aluBReg;
        ctrl.aluControl = aluLoad;
        ctrl.pcSource = pcSrcAluOut;

        case (state)
            stReset:
            begin
                ctrl.regWrite = 1'b1;  // Stack pointer init
                ctrl.regDest = regDstSp;
                ctrl.memToReg = memToRegSpInit;
            end
            stFetchWait:
            begin
                ctrl.iOrD = 1'b0;  // Memory reads at PC
                ctrl.srcAddr = srcAddrPc;
            end
            stFetchLoad:
            begin
                ctrl.irWrite = 1'b1;
                ctrl.aluSrcB = aluBFour;  // PC + 4
                ctrl.aluControl = aluAddOvf;
            end
            stDecode: ctrl.pcWrite = 1'b1;  // Take PC + 4 from ALUOut

            ////////////////////////////////////////////////////////////////
            // ALU and jump register
            ////////////////////////////////////////////////////////////////
            stExecute:
            begin
                ctrl.aluSrcA = 1'b1;
                ctrl.aluSrcB = (decoded.kind == kindAluImm) ? aluBImm : aluBReg;
                ctrl.aluControl = decoded.aluOp;
            end
            stWriteRd, stWriteRt:
            begin
                ctrl.regWrite = 1'b1;
                ctrl.regDest = (state == stWriteRd) ? regDstRd : regDstRt;
            end
            stJumpReg, stJumpRegCommit:
            begin
                ctrl.aluSrcA = 1'b1;  // rs through the ALU
                ctrl.pcWrite = (state == stJumpRegCommit);
                ctrl.pcSource = pcSrcAluResult;
            end

            ////////////////////////////////////////////////////////////////
            // Branches and memory
            ////////////////////////////////////////////////////////////////
            stBranchTarget:
            begin
                ctrl.aluSrcB = aluBBranchOffset;
                ctrl.aluControl = aluAddOvf;
            end
            stBranchCompare, stBranchCommit:
            begin
                ctrl.aluSrcA = 1'b1;
                ctrl.aluControl = decoded.aluOp;  // Condition held for commit
                ctrl.pcWriteCond = (state == stBranchCommit);
            end
            stAddrCalc:
            begin
                ctrl.aluSrcA = 1'b1;
                ctrl.aluSrcB = aluBImm;
                ctrl.aluControl = aluAddOvf;
            end
            stMemRead: ctrl.iOrD = 1'b1;
            stMemLoad:
            begin
                ctrl.sizeHandler = loadSizeCode(decoded.memSize);
                ctrl.memToReg = memToRegMem;
                ctrl.regWrite = 1'b1;
            end
            stMemStore:
            begin
                ctrl.iOrD = 1'b1;
                ctrl.memWrite = 1'b1;
                ctrl.dataSource = 1'b1;  // Store data from rt
                ctrl.sizeHandler = storeSizeCode(decoded.memSize);
            end
            stJump, stJal:
            begin
                ctrl.pcWrite = 1'b1;
                ctrl.pcSource = pcSrcJump;
                ctrl.regWrite = (state == stJal);  // Link in ra
                ctrl.regDest = regDstRa;
                ctrl.memToReg = memToRegPc;
            end

            // Exception states fetch the handler address
            stInvalidOp, stOverflowTrap, stExceptionExit:
            begin
                ctrl.srcAddr = (state == stInvalidOp) ? srcAddrInvalid :
                               (state == stOverflowTrap) ? srcAddrOverflow : srcAddrPc;
                ctrl.sizeHandler = sizeHandlerLw;
                ctrl.memToReg = memToRegException;
                ctrl.regDest = regDstSp;
                ctrl.pcSource = pcSrcException;
                ctrl.pcWrite = (state == stExceptionExit);
            end
            default: ctrl.pcSource = pcSrcAluOut;
        endcase
    end

endmodule

`default_nettype wire

/* hdl/controlUnit.sv */
`timescale 1ns/1ps
`default_nettype none

module controlUnit
    import controlPkg::*;
(
    input  logic                   clk,
    input  logic                   reset,
    input  logic [opcodeWidth-1:0] opcode,
    input  logic [functWidth-1:0]  funct,
    input  logic                   overflow,
    output controlWord_t           ctrl
);

    decodedInstr_t decoded;
    ctrlState_t    state;

    instructionDecoder instructionDecoder_i (
        .opcode  (opcode),
        .funct   (funct),
        .decoded (decoded)
    );

    stateSequencer stateSequencer_i (
        .clk      (clk),
        .reset    (reset),
        .overflow (overflow),
        .decoded  (decoded),
        .state    (state)
    );

    controlEncoder controlEncoder_i (
        .state   (state),
        .decoded (decoded),
        .ctrl    (ctrl)
    );

endmodule

`default_nettype wire

/* verification/clockGen.sv */
`timescale 1ns/1ps
`default_nettype none

module clockGen #(
    parameter int period = 4,
    parameter int resetCycles = 4
)
(
    output logic clk,
    output logic reset
);

    initial
    begin
        clk = 1'b0;
        forever
            #(period / 2) clk = ~clk;
    end

    // Release 1 ns after the last reset edge
    initial
    begin
        reset = 1'b1;
        repeat (resetCycles) @(posedge clk);
        #1 reset = 1'b0;
    end

endmodule

`default_nettype wire

/* verification/controlUnitAssertions.sv */
`timescale 1ns/1ps
`default_nettype none

module controlUnitAssertions
    import controlPkg::*;
(
    input logic         clk,
    input logic         reset,
    input controlWord_t ctrl
);

    int   violationCount = 0;
    logic started = 1'b0;

    always @(posedge clk)
        started <= 1'b1;  // State is unknown before the first edge

    fetchStoreExclusive: assert property (@(posedge clk) disable iff (reset)
        !(ctrl.irWrite && ctrl.memWrite))
    else
    begin
        $error("irWrite and memWrite are high in the same cycle");
        violationCount++;
    end

    singleCondWrite: assert property (@(posedge clk) disable iff (reset)
        ctrl.pcWriteCond |=> !ctrl.pcWriteCond)
    else
    begin
        $error("pcWriteCond is high for more than one cycle");
        violationCount++;
    end

    noFetchInReset: assert property (@(posedge clk)
        started && reset |-> !ctrl.irWrite)
    else
    begin
        $error("irWrite is high while reset is asserted");
        violationCount++;
    end

endmodule

`default_nettype wire

/* verification/controlUnitTb.sv */
`timescale 1ns/1ps
`default_nettype none

module controlUnitTb
    import controlPkg::*;
();

    localparam int clkPeriod = 4;
    localparam int overflowCycle = 2;  // Execute cycle of the add

    typedef enum {chkAlu, chkLink, chkJump, chkBranch, chkLoad, chkStore, chkTrap} checkKind_t;

    typedef struct {
        string                  name;
        logic [opcodeWidth-1:0] opcode;
        logic [functWidth-1:0]  funct;
        logic                   overflow;
        int                     length;  // irWrite to irWrite
        checkKind_t             kind;
        int                     qual;    // regDest, size code, PC source or trap address
        aluCtrl_t               aluOp;
    } tableRow_t;

    logic                   clk;
    logic                   reset;
    logic [opcodeWidth-1:0] opcode;
    logic [functWidth-1:0]  funct;
    logic                   overflow;
    controlWord_t           ctrl;

    tableRow_t rows[$];
    int        errorCount = 0;
    int        cycles;
    int        regWrites;
    int        memWrites;
    int        condWrites;
    int        jumpWrites;
    int        trapCycle;
    int        regDestSeen;
    int        memToRegSeen;
    int        loadSize;
    int        storeSize;
    int        condAlu;
    int        jumpSrc;
    int        execAlu;
    int        execSrcB;
    int        trapSrc;

    clockGen #(.period(clkPeriod), .resetCycles(4)) clockGen_i (.clk(clk), .reset(reset));

    controlUnit controlUnit_i (
        .clk      (clk),
        .reset    (reset),
        .opcode   (opcode),
        .funct    (funct),
        .overflow (overflow),
        .ctrl     (ctrl)
    );

    bind controlUnit controlUnitAssertions controlUnitAssertions_i (
        .clk   (clk),
        .reset (reset),
        .ctrl  (ctrl)
    );

    task automatic addRow(string name, logic [5:0] op, logic [5:0] fn, logic ovf, int length,
                          checkKind_t kind, int qual, aluCtrl_t aluOp);
        tableRow_t row;
        row.name = name;
        row.opcode = op;
        row.funct = fn;
        row.overflow = ovf;
        row.length = length;
        row.kind = kind;
        row.qual = qual;
        row.aluOp = aluOp;
        rows.push_back(row);
    endtask

    ////////////////////////////////////////////////////////////////////
    // Stimulus and expected values
    ////////////////////////////////////////////////////////////////////
    task automatic buildTable();
        addRow("slt", opRType, fnSlt, 1'b0, 6, chkAlu, regDstRd, aluCmp);
        addRow("sub", opRType, fnSub, 1'b0, 6, chkAlu, regDstRd, aluSub);
        addRow("add", opRType, fnAdd, 1'b0, 6, chkAlu, regDstRd, aluAddOvf);
        addRow("and", opRType, fnAnd, 1'b0, 6, chkAlu, regDstRd, aluAnd);
        addRow("or", opRType, fnOr, 1'b0, 6, chkAlu, regDstRd, aluOr);
        addRow("jr", opRType, fnJr, 1'b0, 6, chkJump, pcSrcAluResult, aluLoad);
        addRow("addi", opAddi, 6'h00, 1'b0, 6, chkAlu, regDstRt, aluAddOvf);
        addRow("addiu", opAddiu, 6'h00, 1'b0, 6, chkAlu, regDstRt, aluAddNoOvf);
        addRow("slti", opSlti, 6'h00, 1'b0, 6, chkAlu, regDstRt, aluCmp);
        addRow("beq", opBeq, 6'h00, 1'b0, 7, chkBranch, 0, aluEq);
        addRow("bne", opBne, 6'h00, 1'b0, 7, chkBranch, 0, aluNe);
        addRow("ble", opBle, 6'h00, 1'b0, 7, chkBranch, 0, aluLe);
        addRow("bgt", opBgt, 6'h00, 1'b0, 7, chkBranch, 0, aluGt);
        addRow("lw", opLw, 6'h00, 1'b0, 8, chkLoad, sizeHandlerLw, aluLoad);
        addRow("lh", opLh, 6'h00, 1'b0, 8, chkLoad, sizeHandlerLh, aluLoad);
        addRow("lb", opLb, 6'h00, 1'b0, 8, chkLoad, sizeHandlerLb, aluLoad);
        addRow("sw", opSw, 6'h00, 1'b0, 6, chkStore, sizeHandlerSw, aluLoad);
        addRow("sh", opSh, 6'h00, 1'b0, 8, chkStore, sizeHandlerSh, aluLoad);
        addRow("sb", opSb, 6'h00, 1'b0, 8, chkStore, sizeHandlerSb, aluLoad);
        addRow("j", opJ, 6'h00, 1'b0, 5, chkJump, pcSrcJump, aluLoad);
        addRow("jal", opJal, 6'h00, 1'b0, 5, chkLink, regDstRa, aluLoad);
        addRow("bad opcode", 6'h3f, 6'h00, 1'b0, 6, chkTrap, srcAddrInvalid, aluLoad);
        addRow("bad funct", opRType, 6'h3f, 1'b0, 6, chkTrap, srcAddrInvalid, aluLoad);
        addRow("add overflow", opRType, fnAdd, 1'b1, 7, chkTrap, srcAddrOverflow, aluLoad);
        addRow("add after trap", opRType, fnAdd, 1'b0, 6, chkAlu, regDstRd, aluAddOvf);
    endtask

    task automatic checkValue(string name, string what, int expected, int actual);
        assert (actual == expected)
        else
        begin
            $display("Error: %s %s expected %0d actual %0d", name, what, expected, actual);
            errorCount++;
        end
    endtask

    task automatic watchdog(int timeoutCycles);
        #(timeoutCycles * clkPeriod);
        $display("Timeout: the DUT stopped issuing fetches within %0d cycles", timeoutCycles);
        $display("Testbench failed");
        $finish;
    endtask

    // Starts at the negedge that shows irWrite, ends at the next one
    task automatic runInstruction(tableRow_t row);
        cycles = 0;
        regWrites = 0;
        memWrites = 0;
        condWrites = 0;
        jumpWrites = 0;
        trapCycle = 0;
        trapSrc = srcAddrPc;
        do
        begin
            @(posedge clk);
            cycles++;
            #1;
            if (cycles == 1)
            begin
                opcode = row.opcode;
                funct = row.funct;
            end
            overflow = row.overflow && (cycles == overflowCycle);
            @(negedge clk);
            if (ctrl.regWrite)
            begin
                regWrites++;
                regDestSeen = ctrl.regDest;
                memToRegSeen = ctrl.memToReg;
                loadSize = ctrl.sizeHandler;
            end
            if (ctrl.memWrite)
            begin
                memWrites++;
                storeSize = ctrl.sizeHandler;
            end
            if (ctrl.pcWriteCond)
            begin
                condWrites++;
                condAlu = ctrl.aluControl;
            end
            if (ctrl.pcWrite && cycles > 1)  // Skip the PC + 4 write in decode
            begin
                jumpWrites++;
                jumpSrc = ctrl.pcSource;
            end
            if (cycles == 2)
            begin
                execAlu = ctrl.aluControl;
                execSrcB = ctrl.aluSrcB;
            end
            if (ctrl.pcSource == pcSrcException && trapCycle == 0)
            begin
                trapCycle = cycles;
                trapSrc = ctrl.srcAddr;
            end
        end
        while (!ctrl.irWrite);
    endtask

    task automatic checkRow(tableRow_t row);
        checkValue(row.name, "cycles", row.length, cycles);
        case (row.kind)
            chkAlu:
            begin
                checkValue(row.name, "regWrite pulses", 1, regWrites);
                checkValue(row.name, "regDest", row.qual, regDestSeen);
                checkValue(row.name, "execute aluControl", row.aluOp, execAlu);
                checkValue(row.name, "execute aluSrcB",
                           (row.qual == regDstRt) ? aluBImm : aluBReg, execSrcB);
            end
            chkLink:
            begin
                checkValue(row.name, "regWrite pulses", 1, regWrites);
                checkValue(row.name, "regDest", row.qual, regDestSeen);
                checkValue(row.name, "jump pcWrite pulses", 1, jumpWrites);
            end
            chkJump:
            begin
                checkValue(row.name, "jump pcWrite pulses", 1, jumpWrites);
                checkValue(row.name, "pcSource", row.qual, jumpSrc);
            end
            chkBranch:
            begin
                checkValue(row.name, "pcWriteCond pulses", 1, condWrites);
                checkValue(row.name, "compare aluControl", row.aluOp, condAlu);
            end
            chkLoad:
            begin
                checkValue(row.name, "regWrite pulses", 1, regWrites);
                checkValue(row.name, "memToReg", memToRegMem, memToRegSeen);
                checkValue(row.name, "load size", row.qual, loadSize);
            end
            chkStore:
            begin
                checkValue(row.name, "memWrite pulses", 1, memWrites);
                checkValue(row.name, "store size", row.qual, storeSize);
            end
            default:
            begin
                checkValue(row.name, "trap srcAddr", row.qual, trapSrc);
                if (row.overflow)
                    checkValue(row.name, "trap cycle", overflowCycle + 1, trapCycle);
            end
        endcase
    endtask

    ////////////////////////////////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////////////////////////////////
    initial
    begin
        int timeoutCycles;
        int fetchCycle;
        int violations;
        opcode = '0;
        funct = '0;
        overflow = 1'b0;
        buildTable();
        timeoutCycles = 20;
        foreach (rows[i])
            timeoutCycles += rows[i].length;
        fork
            watchdog(timeoutCycles);
        join_none

        repeat (2) @(negedge clk);
        checkValue("reset", "regWrite", 1, ctrl.regWrite);
        checkValue("reset", "regDest", regDstSp, ctrl.regDest);
        checkValue("reset", "memToReg", memToRegSpInit, ctrl.memToReg);
        checkValue("reset", "other strobes", 0,
                   {ctrl.pcWrite, ctrl.pcWriteCond, ctrl.memWrite, ctrl.irWrite});
        @(negedge reset);
        fetchCycle = 0;
        do
        begin
            @(negedge clk);
            fetchCycle++;
        end
        while (!ctrl.irWrite);
        checkValue("reset", "first fetch cycle", 5, fetchCycle);

        foreach (rows[i])
        begin
            runInstruction(rows[i]);
            checkRow(rows[i]);
        end

        violations = controlUnit_i.controlUnitAssertions_i.violationCount;
        $display("Ran %0d instructions with %0d errors and %0d assertion failures",
                 rows.size(), errorCount, violations);
        if (errorCount == 0 && violations == 0)
            $display("Testbench passed");
        else
            $display("Testbench failed");
        $finish;
    end

endmodule

`default_nettype wire

/* list.f */
hdl/controlPkg.sv
hdl/instructionDecoder.sv
hdl/stateSequencer.sv
hdl/controlEncoder.sv
hdl/controlUnit.sv
verification/clockGen.sv
verification/controlUnitAssertions.sv
verification/controlUnitTb.sv
